/* src/mem_config.svh */
// Geometry and tag width for the tiled memory subsystem.
// Include wherever widths are needed. The bank and slice counts derive from these.
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// logical memory seen by the client
`define MEM_DW        64                // data width
`define MEM_AW        10                // address width, 1024 words

// one hard macro model
`define MEM_MACRO_W   32                // macro data width
`define MEM_MACRO_AW  8                 // macro address width, 256 words

// byte enables, one per byte of the logical word
`define MEM_BE_W      (`MEM_DW/8)

// request tag echoed on read responses
`define MEM_TAG_W     4

`endif

/* src/mem_pkg.sv */
// Shared types for the memory subsystem: opcodes, client request and response,
// and the command bus from the port stage into the tiled wrapper.
`default_nettype none
`include "mem_config.svh"

package mem_pkg;

    // client opcodes
    typedef enum logic [1:0] {
        OP_READ        = 2'd0,          // tagged read
        OP_WRITE       = 2'd1,          // full word write
        OP_WRITE_BYTES = 2'd2           // byte enabled write
    } mem_op_e;

    typedef struct packed {
        mem_op_e                op;
        logic [`MEM_TAG_W-1:0]  tag;
        logic [`MEM_AW-1:0]     addr;
        logic [`MEM_BE_W-1:0]   byte_en;    // only used by OP_WRITE_BYTES
        logic [`MEM_DW-1:0]     wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_TAG_W-1:0]  tag;        // tag of the originating read
        logic [`MEM_DW-1:0]     rdata;
    } mem_rsp_t;

    // macro style command, one access per cycle
    typedef struct packed {
        logic                   ce;         // chip enable
        logic                   we;         // write enable
        logic [`MEM_AW-1:0]     addr;
        logic [`MEM_DW-1:0]     wmask;      // per bit write mask
        logic [`MEM_DW-1:0]     wdata;
    } ram_cmd_t;

endpackage

`default_nettype wire

/* src/macro_ram.sv */
// Behavioral model of a 256 x 32 single port hard macro.
// Bit masked writes and a registered read that holds while ce is low.
`timescale 1ns/100ps
`default_nettype none
`include "mem_config.svh"

module macro_ram (
    input  wire                       clk,
    input  wire                       ce_in,      // chip enable
    input  wire                       we_in,      // write enable, needs ce_in
    input  wire [`MEM_MACRO_AW-1:0]   addr_in,
    input  wire [`MEM_MACRO_W-1:0]    w_mask_in,  // 1 = bit is written
    input  wire [`MEM_MACRO_W-1:0]    wd_in,
    output logic [`MEM_MACRO_W-1:0]   rd_out      // output latch of the macro
);

    localparam int DEPTH = 1 << `MEM_MACRO_AW;

    logic [`MEM_MACRO_W-1:0] mem [DEPTH];         // array core
    logic [`MEM_MACRO_W-1:0] cur_word;            // word at addr_in
    logic [`MEM_MACRO_W-1:0] merged_word;         // masked write result

    assign cur_word    = mem[addr_in];
    assign merged_word = (cur_word & ~w_mask_in) | (wd_in & w_mask_in);

    // write path, unmasked bits keep their value
    always_ff @(posedge clk) begin
        if (ce_in && we_in) begin
            mem[addr_in] <= merged_word;
        end
    end

    // read path, latched only on a read access
    always_ff @(posedge clk) begin
        if (ce_in && !we_in) begin
            rd_out <= cur_word;
        end
    end

endmodule

`default_nettype wire

/* src/spram_tiled.sv */
// Tiles the 1024 x 64 logical memory out of 256 x 32 macros, four banks by two
// slices. Decodes the bank from the upper address bits and merges bank outputs.
`timescale 1ns/100ps
`default_nettype none
`include "mem_config.svh"

module spram_tiled
    import mem_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  ram_cmd_t            cmd,            // registered command from the port
    output logic [`MEM_DW-1:0]  rdata           // valid the cycle after a read
);

    localparam int BANK_W = `MEM_AW - `MEM_MACRO_AW;       // bank index bits
    localparam int BANKS  = 1 << BANK_W;                   // 4 banks
    localparam int SLICES = `MEM_DW / `MEM_MACRO_W;        // 2 macros per bank
    localparam int MW     = `MEM_MACRO_W;

    logic [BANK_W-1:0]          cmd_bank;       // bank of the current command
    logic [`MEM_MACRO_AW-1:0]   cmd_maddr;      // word address inside a macro
    logic [BANK_W-1:0]          bank_q;         // bank of the last access
    logic [MW-1:0]              slice_rd [BANKS][SLICES];

    assign cmd_bank  = cmd.addr[`MEM_AW-1:`MEM_MACRO_AW];
    assign cmd_maddr = cmd.addr[`MEM_MACRO_AW-1:0];

    generate
        for (genvar b = 0; b < BANKS; b++) begin : g_bank
            logic bank_sel;                     // address falls in this bank
            logic bank_ce;
            logic bank_we;

            assign bank_sel = (cmd_bank == BANK_W'(b));
            assign bank_ce  = cmd.ce && bank_sel;
            assign bank_we  = cmd.we && bank_sel;

            // both slices of a bank share ce, we and address
            for (genvar s = 0; s < SLICES; s++) begin : g_slice
                macro_ram u_macro (
                    .clk       (clk),
                    .ce_in     (bank_ce),
                    .we_in     (bank_we),
                    .addr_in   (cmd_maddr),
                    .w_mask_in (cmd.wmask[s*MW +: MW]),
                    .wd_in     (cmd.wdata[s*MW +: MW]),
                    .rd_out    (slice_rd[b][s])
                );
            end
        end
    endgenerate

    // track which bank holds fresh read data, same edge as the macro latch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank_q <= '0;
        end else if (cmd.ce) begin
            bank_q <= cmd_bank;
        end
    end

    // merge, other banks' stale latches never reach rdata
    always_comb begin
        for (int s = 0; s < SLICES; s++) begin
            rdata[s*MW +: MW] = slice_rd[bank_q][s];
        end
    end

endmodule

`default_nettype wire

/* src/mem_port.sv */
// Client front end. Registers each request into a macro command, expands byte
// enables to a bit mask and returns tagged read data two cycles after the request.
`timescale 1ns/100ps
`default_nettype none
`include "mem_config.svh"

module mem_port
    import mem_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 req_valid,      // single cycle strobe
    input  mem_req_t            req,
    output ram_cmd_t            cmd,            // to the tiled wrapper
    input  wire [`MEM_DW-1:0]   rdata,          // from the tiled wrapper
    output logic                rsp_valid,      // one pulse per read
    output mem_rsp_t            rsp
);

    logic [`MEM_DW-1:0]     be_mask;            // byte enables widened to bits
    logic [`MEM_DW-1:0]     nxt_wmask;
    logic                   nxt_we;
    logic                   is_read;

    logic                   ce_q;
    logic                   we_q;
    logic [`MEM_AW-1:0]     addr_q;
    logic [`MEM_DW-1:0]     wmask_q;
    logic [`MEM_DW-1:0]     wdata_q;

    logic [1:0]             rd_pipe;            // read flag, one bit per stage
    logic [`MEM_TAG_W-1:0]  tag_pipe [2];       // tags riding along

    always_comb begin
        for (int i = 0; i < `MEM_BE_W; i++) begin
            be_mask[i*8 +: 8] = {8{req.byte_en[i]}};
        end
    end

    // opcode decode
    always_comb begin
        nxt_we    = 1'b0;
        nxt_wmask = '0;
        case (req.op)
            OP_WRITE: begin
                nxt_we    = 1'b1;
                nxt_wmask = '1;                 // whole word
            end
            OP_WRITE_BYTES: begin
                nxt_we    = 1'b1;
                nxt_wmask = be_mask;
            end
            default: ;                          // read, or unused code
        endcase
    end

    assign is_read = req_valid && (req.op == OP_READ);

    // command control and read flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ce_q      <= 1'b0;
            we_q      <= 1'b0;
            rd_pipe   <= '0;
            rsp_valid <= 1'b0;
        end else begin
            ce_q      <= req_valid;
            we_q      <= req_valid && nxt_we;
            rd_pipe   <= {rd_pipe[0], is_read};
            rsp_valid <= rd_pipe[1];            // data left the macros last edge
        end
    end

    // payload, only loaded when something is there
    always_ff @(posedge clk) begin
        if (req_valid) begin
            addr_q  <= req.addr;
            wmask_q <= nxt_wmask;
            wdata_q <= req.wdata;
        end
        tag_pipe[0] <= req.tag;
        tag_pipe[1] <= tag_pipe[0];
        if (rd_pipe[1]) begin
            rsp.tag   <= tag_pipe[1];
            rsp.rdata <= rdata;
        end
    end

    assign cmd.ce    = ce_q;
    assign cmd.we    = we_q;
    assign cmd.addr  = addr_q;
    assign cmd.wmask = wmask_q;
    assign cmd.wdata = wdata_q;

endmodule

`default_nettype wire

/* src/mem_subsys_top.sv */
// Top of the memory subsystem: port stage in front of the tiled macro wrapper.
// Read responses come back two cycles after the request strobe.
`timescale 1ns/100ps
`default_nettype none
`include "mem_config.svh"

module mem_subsys_top
    import mem_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 req_valid,      // one request per strobe
    input  mem_req_t            req,
    output logic                rsp_valid,
    output mem_rsp_t            rsp
);

    ram_cmd_t               cmd;                // port to wrapper
    logic [`MEM_DW-1:0]     rdata;              // wrapper to port

    mem_port u_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .cmd       (cmd),
        .rdata     (rdata),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    spram_tiled u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .rdata (rdata)
    );

endmodule

`default_nettype wire

/* bench/mem_tb.sv */
// Testbench for the tiled memory subsystem. Drives tagged requests on the falling
// edge, keeps a shadow memory and checks responses by assertions against it.
`timescale 1ns/100ps
`default_nettype none
`include "mem_config.svh"

module mem_tb
    import mem_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int N_REQ      = 4 + 16 + 11 + 11 + 8 + 300;   // requests over all tests
    localparam int N_RAND     = 300;

    typedef struct packed {
        logic [`MEM_TAG_W-1:0]  tag;
        logic [`MEM_DW-1:0]     data;
        logic [`MEM_DW-1:0]     mask;       // bits that hold known data
    } exp_t;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    mem_req_t               req;
    logic                   rsp_valid;
    mem_rsp_t               rsp;
    logic                   rd_req;         // read strobe as seen by the DUT

    logic [`MEM_DW-1:0]     shadow [1 << `MEM_AW];
    logic [`MEM_BE_W-1:0]   known [1 << `MEM_AW];  // bytes written so far
    exp_t                   exp_q [$];
    exp_t                   exp_head;
    integer                 seed = 32'h801e_f1be;
    int                     errors = 0;
    int                     n_checks = 0;
    int                     n_tests = 0;
    int                     test_err_start = 0;
    int                     cyc = 0;

    mem_subsys_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    assign rd_req = req_valid && (req.op == OP_READ);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // no response while or right after reset is held
    assert property (@(posedge clk) (cyc > 1 && !$past(rst_n)) |-> !rsp_valid)
    else begin
        errors++;
        $display("error at %0t: rsp_valid high during reset", $time);
    end

    // one response per read, three sampling edges after the strobe, none for writes
    assert property (@(posedge clk) disable iff (!rst_n) rsp_valid == $past(rd_req, 3))
    else begin
        errors++;
        $display("error at %0t: rsp_valid is %b, latency or count wrong", $time, rsp_valid);
    end

    // response payload against the queue head, sampled mid cycle
    always @(negedge clk) begin
        if (rst_n && rsp_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("a response with tag %0h came while no read was outstanding",
                         rsp.tag);
            end else begin
                exp_head = exp_q.pop_front();
                n_checks++;
                assert (rsp.tag == exp_head.tag &&
                        (rsp.rdata & exp_head.mask) === (exp_head.data & exp_head.mask))
                else begin
                    errors++;
                    $display("error at %0t: got tag %0h data %h, expected tag %0h data %h",
                             $time, rsp.tag, rsp.rdata, exp_head.tag, exp_head.data);
                end
            end
        end
    end

    // one request on the next falling edge, shadow updated byte by byte
    task automatic issue(input mem_op_e op, input logic [`MEM_AW-1:0] addr,
                         input logic [`MEM_BE_W-1:0] be, input logic [`MEM_DW-1:0] wdata,
                         input logic [`MEM_TAG_W-1:0] tag);
        mem_req_t r;
        exp_t     e;
        @(negedge clk);
        r.op      = op;
        r.tag     = tag;
        r.addr    = addr;
        r.byte_en = be;
        r.wdata   = wdata;
        req       = r;
        req_valid = 1'b1;
        if (op == OP_READ) begin
            e.tag  = tag;
            e.data = shadow[addr];
            for (int i = 0; i < `MEM_BE_W; i++) e.mask[i*8 +: 8] = {8{known[addr][i]}};
            exp_q.push_back(e);
        end else begin
            for (int i = 0; i < `MEM_BE_W; i++) begin
                if (op == OP_WRITE || be[i]) begin
                    shadow[addr][i*8 +: 8] = wdata[i*8 +: 8];
                    known[addr][i]         = 1'b1;
                end
            end
        end
    endtask

    // stop driving and wait for the outstanding reads to come back
    task automatic drain();
        @(negedge clk);
        req_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        drain();
        n_tests++;
        $display("test %0d %s finished with %0d errors", n_tests, name,
                 errors - test_err_start);
        test_err_start = errors;
    endtask

    initial begin
        #(CLK_PERIOD * (N_REQ + 200));
        $display("watchdog: the run did not finish within its time limit");
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        logic [1:0]  opi;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        for (int a = 0; a < (1 << `MEM_AW); a++) known[a] = '0;   // memory is not cleared
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // writes alone must never give a response
        for (int i = 0; i < 4; i++) issue(OP_WRITE, 10'(i * 256 + 7), '0, {2{32'(i)}}, 4'(i));
        end_test("reset and write silence");

        for (int i = 0; i < 8; i++) begin
            issue(OP_WRITE, {2'(i), 8'(i * 37 + 5)}, '0,
                  {2{32'(i) * 32'h0101_0101}} ^ 64'hf0f0_0000_0000_ffff, 4'(i));
        end
        for (int i = 0; i < 8; i++) issue(OP_READ, {2'(i), 8'(i * 37 + 5)}, '0, '0, 4'(15 - i));
        end_test("full write and read back");

        issue(OP_WRITE, 10'h0a5, '0, 64'h0123_4567_89ab_cdef, 4'h0);
        for (int i = 0; i < 5; i++) begin
            rnd = $random(seed);
            issue(OP_WRITE_BYTES, 10'h0a5, rnd[7:0], {8{8'(8'hb0 + i)}}, 4'(i));
            issue(OP_READ, 10'h0a5, '0, '0, 4'(i + 1));
        end
        end_test("byte enabled writes");

        for (int b = 0; b < 4; b++) issue(OP_WRITE, {2'(b), 8'h3c}, '0, {8{8'(8'ha0 + b)}}, 4'h0);
        for (int b = 0; b < 4; b++) issue(OP_READ, {2'(b), 8'h3c}, '0, '0, 4'(b + 4));
        issue(OP_WRITE, 10'h2ff, '0, 64'hdead_beef_cafe_f00d, 4'h0);
        issue(OP_WRITE_BYTES, 10'h2ff, 8'h18, 64'h1122_3344_5566_7788, 4'h0);  // bytes 3 and 4
        issue(OP_READ, 10'h2ff, '0, '0, 4'h9);
        end_test("bank and slice isolation");

        // strobe on every cycle, two reads in flight
        for (int i = 7; i >= 0; i--) issue(OP_READ, {2'(i), 8'(i * 37 + 5)}, '0, '0, 4'(8 + i));
        end_test("back to back reads");

        for (int n = 0; n < N_RAND; n++) begin
            rnd = $random(seed);
            opi = rnd[1:0];
            if (opi == 2'd3) opi = 2'd0;                   // unused code folds into read
            if (rnd[31:29] == 3'd0) begin
                @(negedge clk);
                req_valid = 1'b0;                          // idle gap now and then
            end else begin
                issue(mem_op_e'(opi), rnd[23:14] & 10'h31f, rnd[13:6],
                      {$random(seed), $random(seed)}, rnd[5:2]);
            end
        end
        end_test("random mixed traffic");

        $display("summary: %0d tests, %0d responses checked, %0d errors",
                 n_tests, n_checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+src
src/mem_pkg.sv
src/macro_ram.sv
src/spram_tiled.sv
src/mem_port.sv
src/mem_subsys_top.sv
bench/mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it.
# Exit status is 0 only when the run reports a clean pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module mem_tb \
    -Mdir obj_dir

out=$(./obj_dir/Vmem_tb)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
